// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module tb_ysyx_exu_muldiv \
		-Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
ysyx_pkg.sv
ysyx_exu_mul.sv
ysyx_exu_div.sv
ysyx_exu_muldiv.sv
tb_ysyx_exu_muldiv_assertions.sv
tb_ysyx_exu_muldiv.sv

// File: tb_ysyx_exu_muldiv.sv
`timescale 1ns/1ns

module tb_ysyx_exu_muldiv import ysyx_pkg::*; ();

  localparam int XLEN = ysyx_xlen_default;
  localparam int clk_period = 20;
  // Trailing abort windows count as extra requests
  localparam int num_requests = 80;
  localparam int watchdog_ns = num_requests * (XLEN + 4) * clk_period
                               + 5 * clk_period + 2000;
  localparam logic [XLEN-1:0] min_val = {1'b1, {(XLEN-1){1'b0}}};

  logic            clock = 1'b0;
  logic            rst_n;
  logic [XLEN-1:0] in_a;
  logic [XLEN-1:0] in_b;
  logic [4:0]      in_op;
  logic            in_valid;
  logic [XLEN-1:0] out_r;
  logic            out_valid;

  logic [31:0] lfsr = 32'h593;
  int          pass_count = 0;
  int          fail_count = 0;

  always #(clk_period / 2) clock = ~clock;

  ysyx_exu_muldiv #(
    .XLEN(XLEN)
  ) i_dut (
    .clock    (clock),
    .rst_n    (rst_n),
    .in_a     (in_a),
    .in_b     (in_b),
    .in_op    (in_op),
    .in_valid (in_valid),
    .out_r    (out_r),
    .out_valid(out_valid)
  );

  bind ysyx_exu_muldiv tb_ysyx_exu_muldiv_assertions #(
    .XLEN(XLEN)
  ) u_assertions (
    .clock    (clock),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_b     (in_b),
    .out_valid(out_valid),
    .mul_valid(mul_valid),
    .div_valid(div_valid)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_word(output logic [XLEN-1:0] w);
    for (int i = 0; i < XLEN; i++) begin
      lfsr = lfsr_step(lfsr);
      w[i] = lfsr[0];
    end
  endtask

  function automatic string op_name(input logic [4:0] op);
    case (op)
      alu_mul:    return "mul";
      alu_mulh:   return "mulh";
      alu_mulhsu: return "mulhsu";
      alu_mulhu:  return "mulhu";
      alu_div:    return "div";
      alu_divu:   return "divu";
      alu_rem:    return "rem";
      default:    return "remu";
    endcase
  endfunction

  function automatic logic is_divide(input logic [4:0] op);
    return op == alu_div || op == alu_divu || op == alu_rem || op == alu_remu;
  endfunction

  // RISC-V M rules
  function automatic logic [XLEN-1:0] model(input logic [4:0] op,
                                            input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0]      ax;
    logic [2*XLEN-1:0]      bx;
    logic [2*XLEN-1:0]      p;
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic                   overflow;
    ax = (op == alu_mulhu) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
    bx = (op == alu_mulh) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
    p  = ax * bx;
    sa = a;
    sb = b;
    overflow = (a == min_val) && (b == '1);
    case (op)
      alu_mul: return p[XLEN-1:0];
      alu_mulh, alu_mulhsu, alu_mulhu: return p[2*XLEN-1:XLEN];
      alu_div: begin
        if (b == '0) return '1;
        else if (overflow) return min_val;
        else return sa / sb;
      end
      alu_rem: begin
        if (b == '0) return a;
        else if (overflow) return '0;
        else return sa % sb;
      end
      alu_divu: return (b == '0) ? '1 : a / b;
      alu_remu: return (b == '0) ? a : a % b;
      default: return '0;
    endcase
  endfunction

  // Returns just after the edge that samples the request
  task automatic issue(input logic [4:0] op, input logic [XLEN-1:0] a, b);
    @(posedge clock);
    in_op    <= op;
    in_a     <= a;
    in_b     <= b;
    in_valid <= 1'b1;
    @(posedge clock);
    in_valid <= 1'b0;
  endtask

  // Latency counts edges after the sampling edge
  task automatic await_result(output int lat, output logic seen, output logic [XLEN-1:0] r);
    lat  = 0;
    seen = 1'b0;
    r    = '0;
    while (!seen && lat < 2 * XLEN) begin
      @(negedge clock);
      if (out_valid) begin
        seen = 1'b1;
        r    = out_r;
      end else begin
        lat++;
      end
    end
  endtask

  task automatic finish_test(input string name, input logic ok);
    if (ok) begin
      pass_count++;
      $display("ok      %s", name);
    end else begin
      fail_count++;
      $display("failed  %s", name);
    end
  endtask

  task automatic check_result(input string name, input logic [4:0] op,
                              input logic [XLEN-1:0] a, b, input int lat,
                              input logic seen, input logic [XLEN-1:0] got_r,
                              inout logic ok);
    logic [XLEN-1:0] exp_r;
    int              exp_lat;
    exp_r   = model(op, a, b);
    exp_lat = (is_divide(op) && b == '0) ? 1 : XLEN + 1;
    assert (seen) else begin
      $display("%s: no result within %0d cycles of the request", name, 2 * XLEN);
      ok = 1'b0;
    end
    if (seen) begin
      assert (got_r === exp_r) else begin
        $display("[FAIL] %s expected %h actual %h", name, exp_r, got_r);
        ok = 1'b0;
      end
      assert (lat == exp_lat) else begin
        $display("[FAIL] %s latency expected %0d actual %0d", name, exp_lat, lat);
        ok = 1'b0;
      end
    end
  endtask

  task automatic run_op(input string name, input logic [4:0] op,
                        input logic [XLEN-1:0] a, b);
    logic [XLEN-1:0] got_r;
    int              lat;
    logic            seen;
    logic            ok;
    ok = 1'b1;
    issue(op, a, b);
    await_result(lat, seen, got_r);
    check_result(name, op, a, b, lat, seen, got_r, ok);
    finish_test(name, ok);
  endtask

  // Last request forces both operands negative
  task automatic run_random(input logic [4:0] op, input int count);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int i = 0; i < count; i++) begin
      draw_word(a);
      draw_word(b);
      run_op($sformatf("%s_rand_%0d", op_name(op), i), op, a, b);
    end
    draw_word(a);
    draw_word(b);
    run_op($sformatf("%s_neg", op_name(op)), op, a | min_val, b | min_val);
  endtask

  task automatic run_abort(input string name, input logic [4:0] op1, op2);
    logic [XLEN-1:0] a1;
    logic [XLEN-1:0] b1;
    logic [XLEN-1:0] a2;
    logic [XLEN-1:0] b2;
    logic [XLEN-1:0] got_r;
    int              lat;
    int              pulses;
    logic            seen;
    logic            ok;
    ok     = 1'b1;
    pulses = 0;
    draw_word(a1);
    draw_word(b1);
    draw_word(a2);
    draw_word(b2);
    issue(op1, a1, b1);
    repeat (3) begin
      @(negedge clock);
      if (out_valid) pulses++;
    end
    issue(op2, a2, b2);
    await_result(lat, seen, got_r);
    if (seen) pulses++;
    check_result(name, op2, a2, b2, lat, seen, got_r, ok);
    repeat (XLEN + 4) begin
      @(negedge clock);
      if (out_valid) pulses++;
    end
    assert (pulses == 1) else begin
      $display("%s: saw %0d result pulses instead of exactly one", name, pulses);
      ok = 1'b0;
    end
    finish_test(name, ok);
  endtask

  initial begin
    logic [XLEN-1:0] a;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_a     = '0;
    in_b     = '0;
    in_op    = alu_mul;
    repeat (5) @(posedge clock);
    rst_n <= 1'b1;
    repeat (2) @(posedge clock);

    run_random(alu_mul, 8);
    run_random(alu_mulh, 6);
    run_random(alu_mulhsu, 6);
    run_random(alu_mulhu, 6);
    run_random(alu_div, 6);
    run_random(alu_rem, 6);
    run_random(alu_divu, 6);
    run_random(alu_remu, 6);

    draw_word(a);
    run_op("div_by_zero", alu_div, a, '0);
    run_op("divu_by_zero", alu_divu, a, '0);
    run_op("rem_by_zero", alu_rem, a | min_val, '0);
    run_op("remu_by_zero", alu_remu, a, '0);
    run_op("div_overflow", alu_div, min_val, '1);
    run_op("rem_overflow", alu_rem, min_val, '1);
    run_op("mulh_min_min", alu_mulh, min_val, min_val);
    run_op("divu_min_ones", alu_divu, min_val, '1);

    run_abort("abort_mul_by_div", alu_mulh, alu_div);
    run_abort("abort_div_by_mul", alu_remu, alu_mulhsu);
    run_abort("abort_div_by_div", alu_div, alu_rem);

    $display("Tests: %0d passed, %0d failed, %0d assertion errors",
             pass_count, fail_count, i_dut.u_assertions.error_count);
    if (fail_count == 0 && i_dut.u_assertions.error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: tb_ysyx_exu_muldiv_assertions.sv
`timescale 1ns/1ns

module tb_ysyx_exu_muldiv_assertions import ysyx_pkg::*; #(
  parameter int XLEN = ysyx_xlen_default
) (
  input logic            clock,
  input logic            rst_n,
  input logic            in_valid,
  input logic [4:0]      in_op,
  input logic [XLEN-1:0] in_b,
  input logic            out_valid,
  input logic            mul_valid,
  input logic            div_valid
);

  int error_count = 0;

  no_back_to_back: assert property (@(posedge clock) disable iff (!rst_n)
    out_valid |=> !out_valid)
    else begin
      $error("out_valid high on two consecutive cycles");
      error_count++;
    end

  quiet_in_reset: assert property (@(posedge clock) !rst_n |=> !out_valid)
    else begin
      $error("out_valid high during reset");
      error_count++;
    end

  quiet_after_reset: assert property (@(posedge clock) $past(!rst_n) |=> !out_valid)
    else begin
      $error("out_valid high on the cycle after reset");
      error_count++;
    end

  one_engine: assert property (@(posedge clock) disable iff (!rst_n)
    !(mul_valid && div_valid))
    else begin
      $error("both engines raised valid together");
      error_count++;
    end

  // Only a divide-class request with a zero divisor finishes this fast
  no_early_result: assert property (@(posedge clock) disable iff (!rst_n)
    (in_valid && !(in_op[3] && in_b == '0)) |-> ##2 !out_valid)
    else begin
      $error("out_valid on the cycle after a request that cannot finish that fast");
      error_count++;
    end

endmodule

// File: ysyx_exu_div.sv
`timescale 1ns/1ns

module ysyx_exu_div import ysyx_pkg::*; #(
  parameter int XLEN = ysyx_xlen_default
) (
  input  logic            clock,
  input  logic            rst_n,
  input  logic            start,
  input  logic            abort,
  input  logic [XLEN-1:0] in_a,
  input  logic [XLEN-1:0] in_b,
  input  logic [4:0]      in_op,
  output logic [XLEN-1:0] out_r,
  output logic            out_valid
);

  localparam int CW = $clog2(XLEN + 1);
  localparam logic [CW-1:0] last_step = CW'(XLEN);

  logic            busy;
  logic [CW-1:0]   count;
  logic            run;
  logic            done;
  logic            signed_op;
  logic            a_neg_in;
  logic            b_neg_in;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  logic            neg_a;
  logic            neg_b;
  logic            rem_sel;
  logic            div_zero;
  logic [XLEN-1:0] quo;
  logic [XLEN-1:0] rem;
  logic [XLEN-1:0] dvsr;

  logic [XLEN:0]   rem_sh;
  logic [XLEN:0]   diff;
  logic            fits;
  logic [XLEN-1:0] rem_src;
  logic [XLEN-1:0] rem_fix;
  logic [XLEN-1:0] quo_fix;

  assign signed_op = (in_op == alu_div) || (in_op == alu_rem);
  assign a_neg_in  = signed_op & in_a[XLEN-1];
  assign b_neg_in  = signed_op & in_b[XLEN-1];
  assign a_mag     = a_neg_in ? -in_a : in_a;
  assign b_mag     = b_neg_in ? -in_b : in_b;

  assign run  = busy & ~abort;
  assign done = run & (div_zero | (count == last_step));

  // One restoring step, next dividend bit enters from the quotient register
  assign rem_sh = {rem, quo[XLEN-1]};
  assign diff   = rem_sh - {1'b0, dvsr};
  assign fits   = ~diff[XLEN];

  // Zero divisor hands back the dividend, still held in quo
  assign rem_src = div_zero ? quo : rem;
  assign rem_fix = neg_a ? -rem_src : rem_src;
  assign quo_fix = div_zero ? '1 : ((neg_a ^ neg_b) ? -quo : quo);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (abort) begin
        busy <= 1'b0;
      end else if (busy) begin
        if (done) begin
          busy      <= 1'b0;
          out_valid <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      neg_a    <= a_neg_in;
      neg_b    <= b_neg_in;
      rem_sel  <= (in_op == alu_rem) || (in_op == alu_remu);
      div_zero <= in_b == '0;
      quo      <= a_mag;
      dvsr     <= b_mag;
      rem      <= '0;
    end else if (run) begin
      if (done) begin
        out_r <= rem_sel ? rem_fix : quo_fix;
      end else begin
        rem <= fits ? diff[XLEN-1:0] : rem_sh[XLEN-1:0];
        quo <= {quo[XLEN-2:0], fits};
      end
    end
  end

endmodule

// File: ysyx_exu_mul.sv
`timescale 1ns/1ns

module ysyx_exu_mul import ysyx_pkg::*; #(
  parameter int XLEN = ysyx_xlen_default
) (
  input  logic            clock,
  input  logic            rst_n,
  input  logic            start,
  input  logic            abort,
  input  logic [XLEN-1:0] in_a,
  input  logic [XLEN-1:0] in_b,
  input  logic [4:0]      in_op,
  output logic [XLEN-1:0] out_r,
  output logic            out_valid
);

  localparam int CW = $clog2(XLEN + 1);
  localparam logic [CW-1:0] last_step = CW'(XLEN);

  logic              busy;
  logic [CW-1:0]     count;
  logic              run;
  logic              done;
  logic              a_signed;
  logic              b_signed;
  logic              want_hi;
  logic [2*XLEN-1:0] mcand;
  logic [XLEN+1:0]   mplier;
  logic [2*XLEN-1:0] prod;
  logic [2*XLEN-1:0] prod_next;

  // MULHU treats a as unsigned, only MULH treats b as signed
  assign a_signed = in_op != alu_mulhu;
  assign b_signed = in_op == alu_mulh;

  assign run  = busy & ~abort;
  assign done = run & (count == last_step);

  // Booth pair {b[i], b[i-1]} picks add, subtract or keep
  always_comb begin
    case (mplier[1:0])
      2'b01:   prod_next = prod + mcand;
      2'b10:   prod_next = prod - mcand;
      default: prod_next = prod;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (abort) begin
        busy <= 1'b0;
      end else if (busy) begin
        if (done) begin
          busy      <= 1'b0;
          out_valid <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

  // Extra top bit of the multiplier adds back a*2^XLEN for unsigned b
  always_ff @(posedge clock) begin
    if (start) begin
      mcand   <= {{XLEN{a_signed & in_a[XLEN-1]}}, in_a};
      mplier  <= {b_signed & in_b[XLEN-1], in_b, 1'b0};
      prod    <= '0;
      want_hi <= in_op != alu_mul;
    end else if (run) begin
      if (done) begin
        // Last pair is folded into the result register
        out_r <= want_hi ? prod_next[2*XLEN-1:XLEN] : prod_next[XLEN-1:0];
      end else begin
        prod   <= prod_next;
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
    end
  end

endmodule

// File: ysyx_exu_muldiv.sv
`timescale 1ns/1ns

module ysyx_exu_muldiv import ysyx_pkg::*; #(
  parameter int XLEN = ysyx_xlen_default
) (
  input  logic            clock,
  input  logic            rst_n,
  input  logic [XLEN-1:0] in_a,
  input  logic [XLEN-1:0] in_b,
  input  logic [4:0]      in_op,
  input  logic            in_valid,
  output logic [XLEN-1:0] out_r,
  output logic            out_valid
);

  logic            mul_start;
  logic            div_start;
  logic            mul_valid;
  logic            div_valid;
  logic [XLEN-1:0] mul_r;
  logic [XLEN-1:0] div_r;

  assign mul_start = in_valid & is_mul_class(in_op);
  assign div_start = in_valid & is_div_class(in_op);

  // A start on one engine aborts the other
  ysyx_exu_mul #(
    .XLEN(XLEN)
  ) u_mul (
    .clock    (clock),
    .rst_n    (rst_n),
    .start    (mul_start),
    .abort    (div_start),
    .in_a     (in_a),
    .in_b     (in_b),
    .in_op    (in_op),
    .out_r    (mul_r),
    .out_valid(mul_valid)
  );

  ysyx_exu_div #(
    .XLEN(XLEN)
  ) u_div (
    .clock    (clock),
    .rst_n    (rst_n),
    .start    (div_start),
    .abort    (mul_start),
    .in_a     (in_a),
    .in_b     (in_b),
    .in_op    (in_op),
    .out_r    (div_r),
    .out_valid(div_valid)
  );

  // At most one engine is ever busy
  assign out_valid = mul_valid | div_valid;
  assign out_r     = mul_valid ? mul_r : div_r;

endmodule

// File: ysyx_pkg.sv
package ysyx_pkg;

  // Default datapath width
  localparam int ysyx_xlen_default = 32;

  // Opcode field positions
  localparam int op_m_bit   = 4;
  localparam int op_div_bit = 3;

  // RV32M operation codes, multiply class
  localparam logic [4:0] alu_mul    = 5'b10000;
  localparam logic [4:0] alu_mulh   = 5'b10001;
  localparam logic [4:0] alu_mulhsu = 5'b10010;
  localparam logic [4:0] alu_mulhu  = 5'b10011;

  // RV32M operation codes, divide class
  localparam logic [4:0] alu_div    = 5'b11000;
  localparam logic [4:0] alu_divu   = 5'b11001;
  localparam logic [4:0] alu_rem    = 5'b11010;
  localparam logic [4:0] alu_remu   = 5'b11011;

  // Goes to the Booth multiplier
  function automatic logic is_mul_class(input logic [4:0] op);
    return op[op_m_bit] & ~op[op_div_bit];
  endfunction

  // Goes to the restoring divider
  function automatic logic is_div_class(input logic [4:0] op);
    return op[op_m_bit] & op[op_div_bit];
  endfunction

endpackage
